//--- design/core_pkg.sv
package core_pkg;

  localparam int XLEN       = 32;  // data and address width
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // ten result ops, then six compares that only set cmp_true
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // one instruction in flight at a time
  typedef enum logic [1:0] {
    FETCH,
    DECODE,
    EXECUTE,
    MEM_WAIT
  } ctrl_state_e;

endpackage

//--- design/isa_pkg.sv
package isa_pkg;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra, srai

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [19:0] rest;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [12:0] regs;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } s_fmt_t;

  typedef struct packed {
    logic        imm_12;
    logic [5:0]  imm_10_5;
    logic [12:0] regs;
    logic [3:0]  imm_4_1;
    logic        imm_11;
    logic [6:0]  opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [11:0] rest;
  } u_fmt_t;

  typedef struct packed {
    logic        imm_20;
    logic [9:0]  imm_10_1;
    logic        imm_11;
    logic [7:0]  imm_19_12;
    logic [11:0] rest;
  } j_fmt_t;

  // one instruction word, six ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

//--- design/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_start_i,
  input  logic            pc_update_i,
  input  logic            pc_jump_i,
  input  logic [XLEN-1:0] jump_offset_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] pc_plus4_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] instr_q;
  logic            req_q;   // address phase, held until grant
  logic            wait_q;  // granted, response pending
  logic            valid_q;

  assign pc_plus4_o = pc_q + XLEN'(4);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q    <= boot_addr_i;
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (pc_update_i) begin
        pc_q <= pc_jump_i ? pc_q + jump_offset_i : pc_plus4_o;
      end
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && instr_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && instr_rvalid_i) begin
        wait_q  <= 1'b0;
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wait_q && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = pc_q;  // pc only moves in EXECUTE, so stable under req
  assign instr_valid_o = valid_q;
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;

endmodule

//--- design/controller.sv
`timescale 1ns/100ps

module controller import core_pkg::*, isa_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       pc_plus4_i,
  output logic                  fetch_start_o,
  output logic                  pc_update_o,
  output logic                  pc_jump_o,
  output logic [XLEN-1:0]       jump_offset_o,
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic                  rd_we_o,
  output logic [XLEN-1:0]       rd_data_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  output alu_op_e               alu_op_o,
  output logic [XLEN-1:0]       alu_a_o,
  output logic [XLEN-1:0]       alu_b_o,
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic                  cmp_true_i,
  output logic                  mem_start_o,
  output logic                  mem_we_o,
  output logic [XLEN-1:0]       mem_addr_o,
  output logic [XLEN-1:0]       mem_wdata_o,
  input  logic                  mem_done_i,
  input  logic [XLEN-1:0]       mem_rdata_i
);

  ctrl_state_e     state_q;
  logic            fetch_busy_q;  // request handed to the fetch unit
  instr_u          instr_q;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] imm_q;
  logic [6:0]      opcode;
  logic            is_mem;
  logic            writes_rd;

  assign opcode    = instr_q.r.opcode;
  assign is_mem    = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
  assign writes_rd = (opcode == OPC_OP) || (opcode == OPC_OP_IMM) ||
                     (opcode == OPC_LUI) || (opcode == OPC_JAL);

  ////////////////////////////////////////////////////////////
  // decode

  always_comb begin
    case (opcode)
      OPC_LUI:    imm = {instr_q.u.imm, 12'b0};
      OPC_STORE:  imm = {{20{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};
      OPC_BRANCH: imm = {{20{instr_q.b.imm_12}}, instr_q.b.imm_11, instr_q.b.imm_10_5,
                         instr_q.b.imm_4_1, 1'b0};
      OPC_JAL:    imm = {{12{instr_q.j.imm_20}}, instr_q.j.imm_19_12, instr_q.j.imm_11,
                         instr_q.j.imm_10_1, 1'b0};
      default:    imm = {{20{instr_q.i.imm[11]}}, instr_q.i.imm};
    endcase
  end

  always_comb begin
    alu_op_o = ALU_ADD;  // loads, stores, jal
    if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
      case (instr_q.r.funct3)
        F3_ADD_SUB: alu_op_o = (opcode == OPC_OP && instr_q.r.funct7 == F7_ALT) ?
                               ALU_SUB : ALU_ADD;
        F3_SLL:     alu_op_o = ALU_SLL;
        F3_SLT:     alu_op_o = ALU_SLT;
        F3_SLTU:    alu_op_o = ALU_SLTU;
        F3_XOR:     alu_op_o = ALU_XOR;
        F3_SRL_SRA: alu_op_o = (instr_q.r.funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        F3_OR:      alu_op_o = ALU_OR;
        default:    alu_op_o = ALU_AND;
      endcase
    end else if (opcode == OPC_BRANCH) begin
      case (instr_q.r.funct3)
        F3_BNE:  alu_op_o = ALU_NE;
        F3_BLT:  alu_op_o = ALU_LT;
        F3_BGE:  alu_op_o = ALU_GE;
        F3_BLTU: alu_op_o = ALU_LTU;
        F3_BGEU: alu_op_o = ALU_GEU;
        default: alu_op_o = ALU_EQ;  // beq and reserved encodings
      endcase
    end
  end

  assign rs1_addr_o = instr_q.r.rs1;
  assign rs2_addr_o = instr_q.r.rs2;  // same slot in S and B
  assign rd_addr_o  = instr_q.r.rd;
  assign alu_a_o    = (opcode == OPC_JAL) ? pc_i : rs1_data_i;  // jal: alu shows target
  assign alu_b_o    = (opcode == OPC_OP || opcode == OPC_BRANCH) ? rs2_data_i : imm_q;

  ////////////////////////////////////////////////////////////
  // sequencer

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= FETCH;
      fetch_busy_q <= 1'b0;
    end else begin
      if (fetch_start_o) fetch_busy_q <= 1'b1;
      case (state_q)
        FETCH: begin
          if (instr_valid_i) begin
            state_q      <= DECODE;
            fetch_busy_q <= 1'b0;
          end
        end
        DECODE:   state_q <= EXECUTE;
        EXECUTE:  state_q <= is_mem ? MEM_WAIT : FETCH;
        MEM_WAIT: if (mem_done_i) state_q <= FETCH;
        default:  state_q <= FETCH;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) instr_q <= instr_i;
    if (state_q == DECODE) imm_q <= imm;
  end

  assign fetch_start_o = (state_q == FETCH) && !fetch_busy_q;
  assign mem_start_o   = (state_q == EXECUTE) && is_mem;
  assign mem_we_o      = (opcode == OPC_STORE);
  assign mem_addr_o    = alu_result_i;  // rs1 + imm
  assign mem_wdata_o   = rs2_data_i;

  assign pc_update_o   = ((state_q == EXECUTE) && !is_mem) ||
                         ((state_q == MEM_WAIT) && mem_done_i);
  assign pc_jump_o     = (opcode == OPC_JAL) || ((opcode == OPC_BRANCH) && cmp_true_i);
  assign jump_offset_o = imm_q;

  assign rd_we_o = ((state_q == EXECUTE) && writes_rd) ||
                   ((state_q == MEM_WAIT) && mem_done_i && (opcode == OPC_LOAD));

  always_comb begin
    case (opcode)
      OPC_LUI:  rd_data_o = imm_q;
      OPC_JAL:  rd_data_o = pc_plus4_i;  // link
      OPC_LOAD: rd_data_o = mem_rdata_i;
      default:  rd_data_o = alu_result_i;
    endcase
  end

endmodule

//--- design/register_file.sv
`timescale 1ns/100ps

module register_file import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic                  we_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin  // x0 writes dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // asynchronous read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu import core_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_true_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = operand_b_i[4:0];
  assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u  = operand_a_i < operand_b_i;
  assign eq    = operand_a_i == operand_b_i;

  always_comb begin
    result_o   = '0;
    cmp_true_o = 1'b0;
    case (op_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // branch conditions
      ALU_EQ:   cmp_true_o = eq;
      ALU_NE:   cmp_true_o = !eq;
      ALU_LT:   cmp_true_o = lt_s;
      ALU_GE:   cmp_true_o = !lt_s;
      ALU_LTU:  cmp_true_o = lt_u;
      default:  cmp_true_o = !lt_u;  // geu
    endcase
  end

endmodule

//--- design/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit import core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            start_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic            done_o,
  output logic [XLEN-1:0] rdata_o
);

  logic            req_q;
  logic            wait_q;  // one transfer outstanding
  logic            done_q;
  logic            we_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  logic [XLEN-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // request fields held from start until grant
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (wait_q && data_rvalid_i) rdata_q <= data_rdata_i;  // ignored for stores
  end

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign done_o       = done_q;
  assign rdata_o      = rdata_q;

endmodule

//--- design/core_top.sv
`timescale 1ns/100ps

module core_top import core_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [XLEN-1:0] boot_addr_i,
  // instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  // data bus
  output logic            data_req_o,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i
);

  logic                  fetch_start;
  logic                  pc_update;
  logic                  pc_jump;
  logic [XLEN-1:0]       jump_offset;
  logic                  instr_valid;
  logic [XLEN-1:0]       instr;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       pc_plus4;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic                  rd_we;
  logic [XLEN-1:0]       rd_data;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  alu_op_e               alu_op;
  logic [XLEN-1:0]       alu_a;
  logic [XLEN-1:0]       alu_b;
  logic [XLEN-1:0]       alu_result;
  logic                  cmp_true;
  logic                  mem_start;
  logic                  mem_we;
  logic [XLEN-1:0]       mem_addr;
  logic [XLEN-1:0]       mem_wdata;
  logic                  mem_done;
  logic [XLEN-1:0]       mem_rdata;

  ////////////////////////////////////////////////////////////
  // fetch and control

  fetch_unit i_fetch_unit (
    .clk_i(clk_i), .rst_i(rst_i), .boot_addr_i(boot_addr_i),
    .fetch_start_i(fetch_start), .pc_update_i(pc_update),
    .pc_jump_i(pc_jump), .jump_offset_i(jump_offset),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o),
    .instr_gnt_i(instr_gnt_i), .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i(instr_rdata_i),
    .instr_valid_o(instr_valid), .instr_o(instr),
    .pc_o(pc), .pc_plus4_o(pc_plus4)
  );

  controller i_controller (
    .clk_i(clk_i), .rst_i(rst_i),
    .instr_valid_i(instr_valid), .instr_i(instr),
    .pc_i(pc), .pc_plus4_i(pc_plus4),
    .fetch_start_o(fetch_start), .pc_update_o(pc_update),
    .pc_jump_o(pc_jump), .jump_offset_o(jump_offset),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
    .rd_we_o(rd_we), .rd_data_o(rd_data),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
    .alu_result_i(alu_result), .cmp_true_i(cmp_true),
    .mem_start_o(mem_start), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_done_i(mem_done), .mem_rdata_i(mem_rdata)
  );

  ////////////////////////////////////////////////////////////
  // datapath

  register_file i_register_file (
    .clk_i(clk_i), .rst_i(rst_i),
    .raddr_a_i(rs1_addr), .raddr_b_i(rs2_addr), .waddr_i(rd_addr),
    .we_i(rd_we), .wdata_i(rd_data),
    .rdata_a_o(rs1_data), .rdata_b_o(rs2_data)
  );

  alu i_alu (
    .op_i(alu_op), .operand_a_i(alu_a), .operand_b_i(alu_b),
    .result_o(alu_result), .cmp_true_o(cmp_true)
  );

  load_store_unit i_load_store_unit (
    .clk_i(clk_i), .rst_i(rst_i),
    .start_i(mem_start), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .data_req_o(data_req_o), .data_we_o(data_we_o),
    .data_addr_o(data_addr_o), .data_wdata_o(data_wdata_o),
    .data_gnt_i(data_gnt_i), .data_rvalid_i(data_rvalid_i),
    .data_rdata_i(data_rdata_i),
    .done_o(mem_done), .rdata_o(mem_rdata)
  );

endmodule

//--- verification/tb_iss.svh
logic [31:0] iss_regs [32];
logic [31:0] iss_mem [256];
logic [31:0] exp_fetch [$];   // expected instr_addr_o per granted fetch
logic        exp_dwe [$];
logic [31:0] exp_daddr [$];
logic [31:0] exp_dwdata [$];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    F3_ADD_SUB: return alt ? a - b : a + b;
    F3_SLL:     return a << b[4:0];
    F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
    F3_XOR:     return a ^ b;
    F3_SRL_SRA: begin
      if (alt) return $unsigned($signed(a) >>> b[4:0]);
      return a >> b[4:0];
    end
    F3_OR:      return a | b;
    default:    return a & b;
  endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
  case (f3)
    F3_BEQ:  return a == b;
    F3_BNE:  return a != b;
    F3_BLT:  return $signed(a) < $signed(b);
    F3_BGE:  return $signed(a) >= $signed(b);
    F3_BLTU: return a < b;
    default: return a >= b;  // bgeu
  endcase
endfunction

// runs the whole program before the DUT starts
task automatic run_iss(input logic [31:0] boot);
  logic [31:0] pc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] addr;
  logic [31:0] next_pc;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic        wr;
  int          steps;
  exp_fetch.delete();
  exp_dwe.delete();
  exp_daddr.delete();
  exp_dwdata.delete();
  foreach (iss_regs[r]) iss_regs[r] = '0;
  pc = boot;
  steps = 0;
  while (steps < PROG_LEN) begin  // control flow only moves forward
    exp_fetch.push_back(pc);
    if (pc == boot + 32'(4 * (PROG_LEN - 1))) break;  // jump to self
    ins     = prog[int'((pc - boot) >> 2)];
    a       = iss_regs[ins[19:15]];
    b       = iss_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    next_pc = pc + 32'd4;
    res     = '0;
    wr      = 1'b0;
    case (ins[6:0])
      OPC_LUI: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      OPC_OP: begin
        res = alu_ref(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      OPC_OP_IMM: begin
        res = alu_ref(ins[14:12], ins[30] && (ins[14:12] == F3_SRL_SRA), a, imm_i);
        wr  = 1'b1;
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        exp_dwe.push_back(1'b0);
        exp_daddr.push_back(addr);
        exp_dwdata.push_back(32'h0);
        res = iss_mem[addr[9:2]];
        wr  = 1'b1;
      end
      OPC_STORE: begin
        addr = a + imm_s;
        exp_dwe.push_back(1'b1);
        exp_daddr.push_back(addr);
        exp_dwdata.push_back(b);
        iss_mem[addr[9:2]] = b;
      end
      OPC_BRANCH: begin
        if (branch_ref(ins[14:12], a, b)) begin
          next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        res     = pc + 32'd4;  // link
        wr      = 1'b1;
        next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) iss_regs[ins[11:7]] = res;
    pc = next_pc;
    steps++;
  end
endtask

//--- verification/tb_core_top.sv
`timescale 1ns/100ps

module tb_core_top import core_pkg::*, isa_pkg::*; ();

  localparam int          SEED        = 27883;
  localparam int          NUM_TESTS   = 20;
  localparam int          PROG_LEN    = 40;
  localparam logic [31:0] DATA_BASE   = 32'h0000_8000;  // x1 points at this 256-word region
  localparam int          WATCHDOG_NS = NUM_TESTS * PROG_LEN * 20 * 10;

  logic            clk_i          = 1'b0;
  logic            rst_i          = 1'b1;
  logic [XLEN-1:0] boot_addr_i    = '0;
  logic            instr_gnt_i    = 1'b0;
  logic            instr_rvalid_i = 1'b0;
  logic [XLEN-1:0] instr_rdata_i  = '0;
  logic            data_gnt_i     = 1'b0;
  logic            data_rvalid_i  = 1'b0;
  logic [XLEN-1:0] data_rdata_i   = '0;
  logic            instr_req_o;
  logic [XLEN-1:0] instr_addr_o;
  logic            data_req_o;
  logic            data_we_o;
  logic [XLEN-1:0] data_addr_o;
  logic [XLEN-1:0] data_wdata_o;

  logic [31:0] prog [PROG_LEN];
  logic [31:0] dut_mem [256];
  logic [31:0] boot_pc   = '0;
  logic [31:0] final_pc  = '0;
  logic        test_done = 1'b0;
  logic        rst_d     = 1'b0;
  int          cur_test  = 0;
  int          fetch_errs = 0;
  int          data_errs  = 0;
  int          proto_errs = 0;
  int          other_errs = 0;

  `include "tb_iss.svh"

  always #5 clk_i = ~clk_i;

  core_top i_core_top (.*);

  ////////////////////////////////////////////////////////////
  // program generation

  function automatic logic [4:0] pick_rd();
    logic [4:0] r;
    r = 5'($urandom_range(1, 15));
    return (r == 5'd1) ? 5'd0 : r;  // x1 keeps the data base
  endfunction

  function automatic logic [4:0] pick_rs();
    return 5'($urandom_range(0, 15));
  endfunction

  function automatic logic [11:0] mem_offset();
    return 12'(4 * $urandom_range(0, 255));
  endfunction

  function automatic int max_skip(input int i);
    return (PROG_LEN - 1 - i < 4) ? PROG_LEN - 1 - i : 4;
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  task automatic gen_program();
    int          i;
    int          k;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [2:0]  br_f3 [6];
    br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    prog[0] = {DATA_BASE[31:12], 5'd1, OPC_LUI};
    i = 1;
    while (i < PROG_LEN - 1) begin
      rd = pick_rd();
      f3 = 3'($urandom_range(0, 7));
      case ($urandom_range(0, 9))
        0, 1, 2: begin
          imm[11:5] = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(0, 1) == 1) ?
                      F7_ALT : 7'h00;
          prog[i] = {imm[11:5], pick_rs(), pick_rs(), f3, rd, OPC_OP};
        end
        3, 4: begin
          imm = 12'($urandom);
          if (f3 == F3_SLL) imm[11:5] = 7'h00;
          if (f3 == F3_SRL_SRA) imm[11:5] = ($urandom_range(0, 1) == 1) ? F7_ALT : 7'h00;
          prog[i] = {imm, pick_rs(), f3, rd, OPC_OP_IMM};
        end
        5: prog[i] = {20'($urandom), rd, OPC_LUI};
        6: begin
          prog[i] = {mem_offset(), 5'd1, 3'b010, rd, OPC_LOAD};
          if (i < PROG_LEN - 2) begin  // store the loaded value back out
            i++;
            prog[i] = enc_s(mem_offset(), rd);
          end
        end
        7: prog[i] = enc_s(mem_offset(), pick_rs());
        8: begin
          k       = $urandom_range(1, max_skip(i));
          boff    = 13'(4 * k);
          prog[i] = {boff[12], boff[10:5], pick_rs(), pick_rs(),
                     br_f3[int'($urandom_range(0, 5))], boff[4:1], boff[11], OPC_BRANCH};
        end
        default: begin
          k       = $urandom_range(1, max_skip(i));
          joff    = 21'(4 * k);
          prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
        end
      endcase
      i++;
    end
    prog[PROG_LEN-1] = {20'h00000, 5'd0, OPC_JAL};  // jal x0, 0
  endtask

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr < boot_pc || addr > final_pc) return 32'h0;  // opcode 0 runs as no-op
    return prog[int'((addr - boot_pc) >> 2)];
  endfunction

  task automatic show_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %0t %s expected %h got %h", $time, sig, exp, act);
  endtask

  task automatic check_fetch(input logic [31:0] addr);
    logic [31:0] exp;
    if (test_done) return;
    if (exp_fetch.size() == 0) begin
      if (addr == final_pc) begin
        test_done = 1'b1;  // final jump has executed once
      end else begin
        fetch_errs++;
        show_error("instr_addr_o", final_pc, addr);
      end
    end else begin
      exp = exp_fetch.pop_front();
      if (addr !== exp) begin
        fetch_errs++;
        show_error("instr_addr_o", exp, addr);
      end
    end
  endtask

  task automatic check_data();
    logic        e_we;
    logic [31:0] e_addr;
    logic [31:0] e_wdata;
    if (exp_daddr.size() == 0) begin
      other_errs++;
      $display("data access to %h at %0t that the model does not expect", data_addr_o, $time);
      return;
    end
    e_we    = exp_dwe.pop_front();
    e_addr  = exp_daddr.pop_front();
    e_wdata = exp_dwdata.pop_front();
    if (data_we_o !== e_we) begin
      data_errs++;
      show_error("data_we_o", 32'(e_we), 32'(data_we_o));
    end
    if (data_addr_o !== e_addr) begin
      data_errs++;
      show_error("data_addr_o", e_addr, data_addr_o);
    end
    if (e_we && data_wdata_o !== e_wdata) begin
      data_errs++;
      show_error("data_wdata_o", e_wdata, data_wdata_o);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus models

  int          i_wait = -1;
  int          i_lat  = 0;
  logic        i_pend = 1'b0;
  logic        i_hold = 1'b0;   // request seen without grant last edge
  logic [31:0] i_addr = '0;
  logic [31:0] i_word = '0;
  int          d_wait = -1;
  int          d_lat  = 0;
  logic        d_pend = 1'b0;
  logic        d_hold = 1'b0;
  logic        d_we   = 1'b0;
  logic [31:0] d_addr = '0;
  logic [31:0] d_wdata = '0;
  logic [31:0] d_word = '0;

  always @(posedge clk_i) begin
    if (rst_i && rst_d && (instr_req_o !== 1'b0 || data_req_o !== 1'b0)) begin
      proto_errs++;
      $display("bus request not low during reset at %0t", $time);
    end
    rst_d <= rst_i;
  end

  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (rst_i) begin
      i_wait = -1;
      i_pend = 1'b0;
      i_hold = 1'b0;
    end else begin
      if (i_hold && !instr_req_o) begin
        proto_errs++;
        $display("instruction request dropped before grant at %0t", $time);
      end
      if (i_hold && instr_req_o && instr_addr_o !== i_addr) begin
        proto_errs++;
        show_error("instr_addr_o", i_addr, instr_addr_o);
      end
      if (i_pend && instr_req_o) begin
        proto_errs++;
        $display("second instruction request while one is outstanding at %0t", $time);
      end
      if (instr_req_o && instr_gnt_i) begin
        check_fetch(instr_addr_o);
        i_word = fetch_word(instr_addr_o);
        i_pend = 1'b1;
        i_lat  = $urandom_range(0, 2);  // rvalid 1 to 3 cycles after grant
      end else if (instr_req_o && !i_pend) begin
        if (i_wait < 0) i_wait = $urandom_range(0, 3);
        if (i_wait == 0) instr_gnt_i <= 1'b1;
        i_wait--;
      end
      if (i_pend) begin
        if (i_lat == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= i_word;
          i_pend = 1'b0;
        end else begin
          i_lat--;
        end
      end
      i_hold = instr_req_o && !instr_gnt_i;
      i_addr = instr_addr_o;
    end
  end

  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    if (rst_i) begin
      d_wait = -1;
      d_pend = 1'b0;
      d_hold = 1'b0;
    end else begin
      if (d_hold && !data_req_o) begin
        proto_errs++;
        $display("data request dropped before grant at %0t", $time);
      end
      if (d_hold && data_req_o) begin
        if (data_addr_o !== d_addr) begin
          proto_errs++;
          show_error("data_addr_o", d_addr, data_addr_o);
        end
        if (data_we_o !== d_we) begin
          proto_errs++;
          show_error("data_we_o", 32'(d_we), 32'(data_we_o));
        end
        if (data_wdata_o !== d_wdata) begin
          proto_errs++;
          show_error("data_wdata_o", d_wdata, data_wdata_o);
        end
      end
      if (d_pend && data_req_o) begin
        proto_errs++;
        $display("second data request while one is outstanding at %0t", $time);
      end
      if (data_req_o && data_gnt_i) begin
        check_data();
        if (data_we_o) dut_mem[data_addr_o[9:2]] = data_wdata_o;
        d_word = dut_mem[data_addr_o[9:2]];
        d_pend = 1'b1;
        d_lat  = $urandom_range(0, 2);
      end else if (data_req_o && !d_pend) begin
        if (d_wait < 0) d_wait = $urandom_range(0, 3);
        if (d_wait == 0) data_gnt_i <= 1'b1;
        d_wait--;
      end
      if (d_pend) begin
        if (d_lat == 0) begin
          data_rvalid_i <= 1'b1;
          data_rdata_i  <= d_word;
          d_pend = 1'b0;
        end else begin
          d_lat--;
        end
      end
      d_hold  = data_req_o && !data_gnt_i;
      d_we    = data_we_o;
      d_addr  = data_addr_o;
      d_wdata = data_wdata_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    void'($urandom(SEED));
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test = t;
      if (t > 0) begin  // reset is already high for the first test
        @(posedge clk_i);
        rst_i <= 1'b1;
      end
      @(posedge clk_i);
      boot_pc  = 32'h0000_1000 + ($urandom_range(0, 255) << 4);
      final_pc = boot_pc + 32'(4 * (PROG_LEN - 1));
      boot_addr_i <= boot_pc;
      gen_program();
      foreach (dut_mem[w]) begin
        dut_mem[w] = $urandom;
        iss_mem[w] = dut_mem[w];
      end
      run_iss(boot_pc);
      test_done = 1'b0;
      repeat (4) @(posedge clk_i);
      rst_i <= 1'b0;
      wait (test_done);
      if (exp_daddr.size() != 0) begin
        other_errs++;
        $display("test %0d finished with %0d expected data accesses never seen",
                 t, exp_daddr.size());
      end
    end
    $display("errors: fetch %0d, data %0d, bus protocol %0d, other %0d",
             fetch_errs, data_errs, proto_errs, other_errs);
    if (fetch_errs + data_errs + proto_errs + other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: test %0d never reached the final jump of its program", cur_test);
    $display("errors: fetch %0d, data %0d, bus protocol %0d, other %0d",
             fetch_errs, data_errs, proto_errs, other_errs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+verification
design/core_pkg.sv
design/isa_pkg.sv
design/fetch_unit.sv
design/controller.sv
design/register_file.sv
design/alu.sv
design/load_store_unit.sv
design/core_top.sv
verification/tb_core_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_core_top \
  -Mdir obj_dir -o sim_tb || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
